// ==== divsqrt.f ====
+incdir+hdl
hdl/divsqrt_ctrl_pkg.sv
hdl/divsqrt_data_pkg.sv
hdl/divsqrt_decode.sv
hdl/divsqrt_execute.sv
hdl/divsqrt_result.sv
hdl/divsqrt_top.sv
testbench/tb_divsqrt.sv

// ==== hdl/divsqrt_config.svh ====
/* Width settings for the divide and square-root unit
   DIVSQRT_WIDTH must be even and at least 4 */

`ifndef DIVSQRT_CONFIG_SVH
`define DIVSQRT_CONFIG_SVH

// Operand and result width in bits
`define DIVSQRT_WIDTH 16

// Caller tag width, returned untouched with the result
`define DIVSQRT_TAG_WIDTH 4

`endif

// ==== hdl/divsqrt_ctrl_pkg.sv ====
/* Control encodings of the divide and square-root unit */

`default_nettype none

package divsqrt_ctrl_pkg;

  // Operation select, anything but DIV runs as a square root
  typedef enum logic {
    DIV  = 1'b0,
    SQRT = 1'b1
  } op_e;

  // Issue, busy and hold control
  typedef enum logic [1:0] {IDLE, BUSY, HOLD} ctrl_state_e;

endpackage

`default_nettype wire

// ==== hdl/divsqrt_data_pkg.sv ====
/* Data-path types of the divide and square-root unit
   Compile divsqrt_ctrl_pkg first, since the issue record carries its op_e */

`default_nettype none

`include "divsqrt_config.svh"

package divsqrt_data_pkg;

  typedef logic [`DIVSQRT_WIDTH-1:0]     operand_t;  // Operand or result word
  typedef logic [`DIVSQRT_TAG_WIDTH-1:0] tag_t;      // Caller tag
  typedef logic [$clog2(`DIVSQRT_WIDTH+1)-1:0] count_t; // Iteration counter

  // Result flags
  typedef struct packed {
    logic div_by_zero; // Divisor was zero
    logic inexact;     // Remainder not zero
  } status_t;

  // Everything the engine needs for one operation
  typedef struct packed {
    divsqrt_ctrl_pkg::op_e op;
    operand_t              operand_a; // Dividend or radicand
    operand_t              operand_b; // Divisor, unused for sqrt
  } issue_t;

  // One finished result
  typedef struct packed {
    operand_t value;
    status_t  status;
  } result_t;

endpackage

`default_nettype wire

// ==== hdl/divsqrt_decode.sv ====
/* Request capture stage, one operation in flight at a time
   The tag register holds until the next accept and feeds tag_o directly */

`timescale 1ns/1ps
`default_nettype none

module divsqrt_decode (
  input  logic                            clk_i,
  input  logic                            arst_n_i,
  input  logic                            flush_i,
  input  logic                            in_valid_i,
  input  logic                            issue_grant_i,
  input  divsqrt_ctrl_pkg::op_e           op_i,
  input  divsqrt_data_pkg::operand_t      operand_a_i,
  input  divsqrt_data_pkg::operand_t      operand_b_i,
  input  divsqrt_data_pkg::tag_t          tag_i,
  output logic                            accepted_o,
  output logic                            start_o,
  output divsqrt_data_pkg::issue_t        issue_o,
  output divsqrt_data_pkg::tag_t          tag_o
);
  import divsqrt_ctrl_pkg::*;
  import divsqrt_data_pkg::*;

  // ----------------------------------------------------------------------
  // Accept and decode
  // ----------------------------------------------------------------------
  logic   accept;   // Request handshake completes this edge
  issue_t issue_d;  // Decoded request
  issue_t issue_q;
  tag_t   tag_q;
  logic   start_q;

  assign accept = in_valid_i & issue_grant_i & ~flush_i; // Flush blocks new work

  always_comb begin
    issue_d.op        = (op_i == DIV) ? DIV : SQRT; // Unknown codes run as sqrt
    issue_d.operand_a = operand_a_i;
    issue_d.operand_b = operand_b_i;
  end

  // ----------------------------------------------------------------------
  // Issue record and tag
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (accept) begin
      issue_q <= issue_d;
      tag_q   <= tag_i;   // Kept until the next accept
    end
  end

  // Start follows the accepting edge by one cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      start_q <= 1'b0;
    end else begin
      start_q <= accept;
    end
  end

  assign accepted_o = accept;   // Lets the FSM leave IDLE
  assign start_o    = start_q;
  assign issue_o    = issue_q;
  assign tag_o      = tag_q;

endmodule

`default_nettype wire

// ==== hdl/divsqrt_execute.sv ====
/* Radix-2 restoring engine on unsigned integers, floor quotient and floor root
   DIV takes DIVSQRT_WIDTH cycles and SQRT half of that, issue_i must stay stable
   until done, result_o is valid only while done_o is high */

`timescale 1ns/1ps
`default_nettype none

`include "divsqrt_config.svh"

module divsqrt_execute (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       flush_i,
  input  logic                       start_i,
  input  divsqrt_data_pkg::issue_t   issue_i,
  output logic                       done_o,
  output divsqrt_data_pkg::result_t  result_o
);
  import divsqrt_ctrl_pkg::*;
  import divsqrt_data_pkg::*;

  localparam int unsigned W = `DIVSQRT_WIDTH;

  logic         is_div;
  logic         running_q;   // Iterations in progress
  logic         done_q;
  count_t       cnt_q;       // Iterations left
  logic [W:0]   rem_q;       // Partial remainder
  operand_t     src_q;       // Dividend or radicand, consumed from the top
  operand_t     acc_q;       // Quotient or root, built from the bottom
  logic [W:0]   shifted;     // Remainder with the next source bits
  logic [W:0]   divisor;     // Value to trial-subtract
  logic [W+1:0] trial;       // One bit wider to catch the borrow
  logic         bit_ok;      // Subtraction fits, result bit is one
  logic         div_by_zero;

  assign is_div = (issue_i.op == DIV);

  // ----------------------------------------------------------------------
  // Trial subtraction
  // ----------------------------------------------------------------------
  always_comb begin
    if (is_div) begin
      shifted = {rem_q[W-1:0], src_q[W-1]};          // One dividend bit
      divisor = {1'b0, issue_i.operand_b};
    end else begin
      shifted = {rem_q[W-2:0], src_q[W-1:W-2]};      // One radicand bit pair
      divisor = {acc_q[W-2:0], 2'b01};               // 4 * root + 1
    end
    trial  = {1'b0, shifted} - {1'b0, divisor};
    bit_ok = ~trial[W+1];
  end

  // ----------------------------------------------------------------------
  // Iteration control
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      running_q <= 1'b0;
      cnt_q     <= '0;
      done_q    <= 1'b0;
    end else if (flush_i) begin
      running_q <= 1'b0;   // Abandon the operation
      cnt_q     <= '0;
      done_q    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (start_i) begin
        running_q <= 1'b1;
        cnt_q     <= is_div ? count_t'(W) : count_t'(W / 2);
      end else if (running_q) begin
        cnt_q <= cnt_q - count_t'(1);
        if (cnt_q == count_t'(1)) begin   // Last step this edge
          running_q <= 1'b0;
          done_q    <= 1'b1;
        end
      end
    end
  end

  // Data path, one result bit per cycle
  always_ff @(posedge clk_i) begin
    if (start_i) begin
      rem_q <= '0;
      acc_q <= '0;
      src_q <= issue_i.operand_a;
    end else if (running_q) begin
      rem_q <= bit_ok ? trial[W:0] : shifted;   // Restore on borrow
      acc_q <= {acc_q[W-2:0], bit_ok};
      src_q <= is_div ? {src_q[W-2:0], 1'b0} : {src_q[W-3:0], 2'b00};
    end
  end

  // ----------------------------------------------------------------------
  // Result and flags
  // ----------------------------------------------------------------------
  assign div_by_zero = is_div & (issue_i.operand_b == '0);

  always_comb begin
    result_o.value              = div_by_zero ? '1 : acc_q;   // All ones on x/0
    result_o.status.div_by_zero = div_by_zero;
    result_o.status.inexact     = (rem_q != '0) & ~div_by_zero;
  end

  assign done_o = done_q;

endmodule

`default_nettype wire

// ==== hdl/divsqrt_result.sv ====
/* Issue, busy and hold control with the output select
   A result refused downstream waits in the hold register, flush drops it */

`timescale 1ns/1ps
`default_nettype none

module divsqrt_result (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  input  logic                       flush_i,
  input  logic                       accepted_i,
  input  logic                       done_i,
  input  divsqrt_data_pkg::result_t  result_i,
  input  logic                       out_ready_i,
  output logic                       issue_grant_o,
  output logic                       out_valid_o,
  output divsqrt_data_pkg::result_t  result_o,
  output logic                       busy_o
);
  import divsqrt_ctrl_pkg::*;
  import divsqrt_data_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        grant;      // Upstream may hand over a request
  logic        out_valid;  // Offer result downstream
  logic        busy;       // Operation or result in flight
  logic        hold_en;    // Park the engine result
  result_t     held_q;

  // ----------------------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------------------
  always_comb begin
    state_d   = state_q;
    grant     = 1'b0;
    out_valid = 1'b0;
    busy      = 1'b0;
    hold_en   = 1'b0;

    unique case (state_q)
      IDLE: begin
        grant = 1'b1;                    // Waiting for work
        if (accepted_i) state_d = BUSY;
      end
      BUSY: begin
        busy = 1'b1;
        if (done_i) begin
          out_valid = 1'b1;              // Offer engine result directly
          if (out_ready_i) begin
            grant   = 1'b1;              // Taken, next request may enter
            state_d = accepted_i ? BUSY : IDLE;
          end else begin
            hold_en = 1'b1;              // Downstream stalled
            state_d = HOLD;
          end
        end
      end
      HOLD: begin
        busy      = 1'b1;
        out_valid = 1'b1;                // Keep offering held result
        if (out_ready_i) begin
          grant   = 1'b1;
          state_d = accepted_i ? BUSY : IDLE;
        end
      end
      default: state_d = IDLE;
    endcase

    // Flush overrides everything
    if (flush_i) begin
      out_valid = 1'b0;
      busy      = 1'b0;
      state_d   = IDLE;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ----------------------------------------------------------------------
  // Hold register and output select
  // ----------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (hold_en) held_q <= result_i;
  end

  assign result_o      = (state_q == HOLD) ? held_q : result_i; // Held data first
  assign issue_grant_o = grant;
  assign out_valid_o   = out_valid;
  assign busy_o        = busy;

endmodule

`default_nettype wire

// ==== hdl/divsqrt_top.sv ====
/* Multi-cycle unsigned divide and square root with valid/ready on both sides
   One operation in flight, latency WIDTH+1 for DIV and WIDTH/2+1 for SQRT */

`timescale 1ns/1ps
`default_nettype none

module divsqrt_top (
  input  logic                       clk_i,
  input  logic                       arst_n_i,
  // Request side
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  input  divsqrt_ctrl_pkg::op_e      op_i,
  input  divsqrt_data_pkg::operand_t operand_a_i,
  input  divsqrt_data_pkg::operand_t operand_b_i,
  input  divsqrt_data_pkg::tag_t     tag_i,
  input  logic                       flush_i,
  // Result side
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  output divsqrt_data_pkg::result_t  result_o,
  output divsqrt_data_pkg::tag_t     tag_o,
  output logic                       busy_o
);
  import divsqrt_data_pkg::*;

  logic    accepted;     // Request taken this edge
  logic    start;        // Engine kick-off
  logic    done;         // Engine finished
  issue_t  issue;        // Registered request
  result_t exec_result;  // Engine output

  divsqrt_decode u_decode (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .flush_i       (flush_i),
    .in_valid_i    (in_valid_i),
    .issue_grant_i (in_ready_o),
    .op_i          (op_i),
    .operand_a_i   (operand_a_i),
    .operand_b_i   (operand_b_i),
    .tag_i         (tag_i),
    .accepted_o    (accepted),
    .start_o       (start),
    .issue_o       (issue),
    .tag_o         (tag_o)
  );

  divsqrt_execute u_execute (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .flush_i  (flush_i),
    .start_i  (start),
    .issue_i  (issue),
    .done_o   (done),
    .result_o (exec_result)
  );

  divsqrt_result u_result (
    .clk_i         (clk_i),
    .arst_n_i      (arst_n_i),
    .flush_i       (flush_i),
    .accepted_i    (accepted),
    .done_i        (done),
    .result_i      (exec_result),
    .out_ready_i   (out_ready_i),
    .issue_grant_o (in_ready_o),
    .out_valid_o   (out_valid_o),
    .result_o      (result_o),
    .busy_o        (busy_o)
  );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Compile and run the divide and square-root testbench with Verilator
set -e
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_divsqrt -f divsqrt.f
./obj_dir/Vtb_divsqrt | tee "$LOG"

if grep -q "^Testbench passed$" "$LOG"; then
  exit 0
fi
echo "Simulation did not pass, see $LOG"
exit 1

// ==== testbench/tb_divsqrt.sv ====
/* Random divide, divide-by-zero and square-root traffic with stalls and flushes
   Checks results, tags, latency, hold stability and flush against a behavioural model */

`timescale 1ns/1ps
`default_nettype none

`include "divsqrt_config.svh"

module tb_divsqrt;
  import divsqrt_ctrl_pkg::*;
  import divsqrt_data_pkg::*;

  localparam int unsigned W          = `DIVSQRT_WIDTH;
  localparam int unsigned NUM_OPS    = 80;
  localparam int unsigned MAX_STALL  = 8;
  localparam int unsigned OP_CYCLES  = W + 2 + MAX_STALL + W / 2 + 4; // Gap and flush included
  localparam int unsigned TIMEOUT_NS = (NUM_OPS * OP_CYCLES + 50) * 100;

  // Expected entry pushed at the accepting edge
  typedef struct packed {
    op_e         op;
    operand_t    a;
    operand_t    b;
    tag_t        tag;
    logic [31:0] acc_cycle;   // Negedge count when accepted
  } expect_t;

  logic     clk_i, arst_n_i, in_valid_i, flush_i, out_ready_i;
  op_e      op_i;
  operand_t operand_a_i, operand_b_i;
  tag_t     tag_i;
  logic     in_ready_o, out_valid_o, busy_o;
  result_t  result_o;
  tag_t     tag_o;

  int unsigned errors    = 0;
  int unsigned n_checked = 0;
  int unsigned n_flushed = 0;
  int unsigned cycle     = 0;
  logic        valid_prev = 1'b0;
  expect_t     exp_q[$];

  divsqrt_top dut (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .tag_i       (tag_i),
    .flush_i     (flush_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_o    (result_o),
    .tag_o       (tag_o),
    .busy_o      (busy_o)
  );

  task automatic report_error(input string msg);
    errors++;
    $display("error %0t: %s", $time, msg);
  endtask

  // Floor square root by counting up
  function automatic int unsigned floor_sqrt(input int unsigned a);
    int unsigned r;
    r = 0;
    while ((r + 1) * (r + 1) <= a) r++;
    return r;
  endfunction

  // Holds the request until the negedge shows in_ready_o and returns at the accepting edge
  task automatic issue_op(input op_e op, input operand_t a, input operand_t b, input tag_t tag);
    in_valid_i  <= 1'b1;
    op_i        <= op;
    operand_a_i <= a;
    operand_b_i <= b;
    tag_i       <= tag;
    @(negedge clk_i);
    while (!in_ready_o) @(negedge clk_i);
    @(posedge clk_i);
    in_valid_i  <= 1'b0;
  endtask

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;   // 100 ns period
  end

  // --------------------------------------------------------------------
  // Protocol assertions
  // --------------------------------------------------------------------
  a_hold_stable: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $past(out_valid_o && !out_ready_i) && !flush_i |->
      out_valid_o && $stable(result_o) && $stable(tag_o))
    else report_error("stalled result dropped or changed");

  a_hold_no_issue: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i |-> !in_ready_o)
    else report_error("in_ready_o high while result is stalled");

  a_flush_clears: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    $past(flush_i) |-> !out_valid_o && !busy_o)
    else report_error("out_valid_o or busy_o high after flush");

  // Busy from the accept until the result is taken
  a_busy_high: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    !flush_i && ($past(in_valid_i && in_ready_o && !flush_i) ||
                 $past(busy_o && !(out_valid_o && out_ready_i) && !flush_i)) |-> busy_o)
    else report_error("busy_o low while an operation is in flight");

  a_idle_not_busy: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    in_ready_o && !out_valid_o |-> !busy_o)
    else report_error("busy_o high while idle");

  // --------------------------------------------------------------------
  // Scoreboard sampled mid-cycle where all signals are settled
  // --------------------------------------------------------------------
  always @(negedge clk_i) begin : scoreboard
    expect_t     head;
    expect_t     entry;
    int unsigned ua, ub, got, want, lat;
    logic        want_dbz, want_inexact;
    if (flush_i) exp_q.delete();   // Flushed op never returns
    if (out_valid_o && !valid_prev) begin
      assert (exp_q.size() != 0) else report_error("result offered with nothing pending");
      if (exp_q.size() != 0) begin
        lat = (exp_q[0].op == DIV) ? W + 1 : W / 2 + 1;
        // Accept seen before its edge, rise seen after its edge
        assert (cycle - exp_q[0].acc_cycle == lat + 1)
          else report_error($sformatf("latency %0d, expected %0d",
                                      cycle - exp_q[0].acc_cycle - 1, lat));
      end
    end
    if (out_valid_o && out_ready_i && exp_q.size() != 0) begin
      head = exp_q.pop_front();
      ua   = 32'(head.a);
      ub   = 32'(head.b);
      got  = 32'(result_o.value);
      if (head.op == DIV && ub == 0) begin
        want         = (1 << W) - 1;   // All ones
        want_dbz     = 1'b1;
        want_inexact = 1'b0;
      end else if (head.op == DIV) begin
        want         = ua / ub;
        want_dbz     = 1'b0;
        want_inexact = (ua % ub) != 0;
      end else begin
        want         = floor_sqrt(ua);
        want_dbz     = 1'b0;
        want_inexact = (want * want) != ua;
        assert (got * got <= ua && ua < (got + 1) * (got + 1))
          else report_error($sformatf("root %0d outside bounds of %0d", got, ua));
      end
      want = want & ((1 << W) - 1);
      assert (got == want)
        else report_error($sformatf("op %s a=%0d b=%0d gave %0d, expected %0d",
                                    (head.op == DIV) ? "DIV" : "SQRT", ua, ub, got, want));
      assert (result_o.status.div_by_zero == want_dbz)
        else report_error($sformatf("div_by_zero %0b, expected %0b",
                                    result_o.status.div_by_zero, want_dbz));
      assert (result_o.status.inexact == want_inexact)
        else report_error($sformatf("inexact %0b, expected %0b",
                                    result_o.status.inexact, want_inexact));
      assert (tag_o == head.tag)
        else report_error($sformatf("tag %0h, expected %0h", tag_o, head.tag));
      n_checked++;
    end
    if (in_valid_i && in_ready_o && !flush_i) begin
      entry.op        = op_i;
      entry.a         = operand_a_i;
      entry.b         = operand_b_i;
      entry.tag       = tag_i;
      entry.acc_cycle = cycle;
      exp_q.push_back(entry);
    end
    valid_prev = out_valid_o;
    cycle++;
  end

  // Downstream sink ready early for a zero stall or after 1 to 8 stalled cycles
  initial begin : sink
    int unsigned stall;
    out_ready_i = 1'b0;
    forever begin
      stall = $urandom_range(MAX_STALL);
      @(posedge clk_i);
      out_ready_i <= (stall == 0);
      @(negedge clk_i);
      while (!out_valid_o) @(negedge clk_i);
      if (stall != 0) begin
        repeat (stall - 1) @(negedge clk_i);
        @(posedge clk_i);
        out_ready_i <= 1'b1;
        @(negedge clk_i);
      end
    end
  end

  initial begin : watchdog
    #(TIMEOUT_NS);
    $display("timeout: operations did not complete within %0d ns", TIMEOUT_NS);
    $display("Testbench failed");
    $finish;
  end

  // --------------------------------------------------------------------
  // Main stimulus
  // --------------------------------------------------------------------
  initial begin : stimulus
    int unsigned kind;
    int unsigned sq;
    operand_t    a;
    tag_t        tag;
    void'($urandom(32'ha98f_6c74));
    arst_n_i    = 1'b0;
    in_valid_i  = 1'b0;
    flush_i     = 1'b0;
    op_i        = DIV;
    operand_a_i = '0;
    operand_b_i = '0;
    tag_i       = '0;
    repeat (3) @(posedge clk_i);
    arst_n_i <= 1'b1;
    @(negedge clk_i);
    assert (!out_valid_o && !busy_o && in_ready_o)
      else report_error("outputs not in reset state after reset");
    @(posedge clk_i);
    for (int unsigned i = 0; i < NUM_OPS; i++) begin
      kind = $urandom_range(9);
      a    = operand_t'($urandom);
      tag  = tag_t'($urandom);
      sq   = $urandom_range(255);
      case (kind)
        0:       issue_op(DIV, a, '0, tag);                              // Divide by zero
        1, 2:    issue_op(DIV, a, operand_t'($urandom_range(15, 1)), tag);
        3, 4, 5: issue_op(DIV, a, operand_t'($urandom_range(65535, 1)), tag);
        6:       issue_op(SQRT, operand_t'(sq * sq), operand_t'($urandom), tag); // Exact root
        default: issue_op(SQRT, a, operand_t'($urandom), tag);
      endcase
      if ($urandom_range(5) == 0) begin
        repeat ($urandom_range(W / 2)) @(posedge clk_i);
        flush_i <= 1'b1;
        @(posedge clk_i);
        flush_i <= 1'b0;
        n_flushed++;
      end
      repeat ($urandom_range(2)) @(posedge clk_i);   // Zero gap gives back-to-back
    end
    @(negedge clk_i);
    while (busy_o) @(negedge clk_i);
    repeat (2) @(negedge clk_i);
    assert (exp_q.size() == 0) else report_error("accepted request never returned a result");
    $display("checked %0d results, %0d flushes, %0d errors", n_checked, n_flushed, errors);
    if (errors == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
